// ==== hdl/adc_input_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_input_stage (
    input  wire                                  clk_adc,
    input  wire                                  rst,
    input  wire tweezer_pkg::sample_t            adc_a,
    input  wire tweezer_pkg::sample_t            adc_b,
    input  wire tweezer_pkg::sample_t            adc_c,
    input  wire tweezer_pkg::sample_t            adc_d,
    input  wire                                  adc_valid,
    input  wire [1:0]                            ch_sel,
    output logic [tweezer_pkg::NUM_CHANNELS-1:0] sat_flags,
    output logic                                 overrun,
    sample_if.src                                smp
);

    tweezer_pkg::sample_t chan [tweezer_pkg::NUM_CHANNELS];
    logic [tweezer_pkg::NUM_CHANNELS-1:0] chan_sat;
    logic blocked;

    assign chan[0] = adc_a;
    assign chan[1] = adc_b;
    assign chan[2] = adc_c;
    assign chan[3] = adc_d;

    always_comb begin
        for (int i = 0; i < tweezer_pkg::NUM_CHANNELS; i++) begin
            chan_sat[i] = (chan[i] == tweezer_pkg::SAT_POS) ||
                          (chan[i] == tweezer_pkg::SAT_NEG);
        end
    end

    // Holding register still full and not taken this cycle
    assign blocked = smp.valid && !smp.ready;

    always_ff @(posedge clk_adc) begin
        if (rst) begin
            smp.valid <= 1'b0;
            sat_flags <= '0;
            overrun   <= 1'b0;
        end else if (adc_valid) begin
            sat_flags <= chan_sat;
            if (blocked) begin
                overrun <= 1'b1;
            end else begin
                smp.valid <= 1'b1;
            end
        end else if (smp.ready) begin
            smp.valid <= 1'b0;
        end
    end

    // Sample payload, loaded only when the slot is free
    always_ff @(posedge clk_adc) begin
        if (adc_valid && !blocked) begin
            smp.data      <= chan[ch_sel];
            smp.saturated <= chan_sat[ch_sel];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dac_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module dac_serializer (
    input  wire                        clk_adc,
    input  wire                        rst,
    input  wire                        out_valid,
    output logic                       out_ready,
    input  wire tweezer_pkg::sample_t  out_data,
    output logic                       dac_sclk,
    output logic                       dac_cs_n,
    output logic                       dac_sdo
);

    logic [tweezer_pkg::DAC_BITS-1:0]                  shreg;
    logic [$clog2(2*tweezer_pkg::DAC_BITS)-1:0]        bit_cnt;
    logic [$clog2(tweezer_pkg::CS_IDLE_CYCLES+1)-1:0]  gap_cnt;
    logic                                              accept;
    logic                                              last_cycle;

    // Idle means cs_n high and the gap time served
    assign out_ready  = dac_cs_n && (gap_cnt == '0);
    assign accept     = out_valid && out_ready;
    assign last_cycle = (bit_cnt == ($bits(bit_cnt))'(2*tweezer_pkg::DAC_BITS - 1));

    assign dac_sdo = shreg[tweezer_pkg::DAC_BITS-1];

    always_ff @(posedge clk_adc) begin
        if (rst) begin
            dac_cs_n <= 1'b1;
            dac_sclk <= 1'b0;
            shreg    <= '0;
            bit_cnt  <= '0;
            gap_cnt  <= '0;
        end else if (accept) begin
            dac_cs_n <= 1'b0;
            dac_sclk <= 1'b0;
            shreg    <= out_data + tweezer_pkg::DAC_OFFSET;
            bit_cnt  <= '0;
        end else if (!dac_cs_n) begin
            dac_sclk <= !dac_sclk;
            bit_cnt  <= bit_cnt + 1'b1;
            // Next bit goes out on the falling sclk edge
            if (dac_sclk) begin
                shreg <= shreg << 1;
            end
            if (last_cycle) begin
                dac_cs_n <= 1'b1;
                dac_sclk <= 1'b0;
                gap_cnt  <= ($bits(gap_cnt))'(tweezer_pkg::CS_IDLE_CYCLES - 1);
            end
        end else if (gap_cnt != '0) begin
            gap_cnt <= gap_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pi_coeff_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Live PI settings, level signals
interface pi_coeff_if;
    tweezer_pkg::coeff_t  kp;
    tweezer_pkg::coeff_t  ki;
    tweezer_pkg::sample_t setpoint;
    tweezer_pkg::limit_t  limit_hi;
    tweezer_pkg::limit_t  limit_lo;

    modport regs (
        output kp, ki, setpoint, limit_hi, limit_lo
    );

    modport ctrl (
        input  kp, ki, setpoint, limit_hi, limit_lo
    );
endinterface

`default_nettype wire

// ==== hdl/pi_config_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module pi_config_regs (
    input  wire                            clk_adc,
    input  wire                            rst,
    input  wire                            cfg_valid,
    input  wire tweezer_pkg::cfg_addr_t    cfg_addr,
    input  wire tweezer_pkg::cfg_payload_u cfg_payload,
    pi_coeff_if.regs                       coeff
);

    always_ff @(posedge clk_adc) begin
        if (rst) begin
            coeff.kp       <= tweezer_pkg::KP_RESET;
            coeff.ki       <= tweezer_pkg::KI_RESET;
            coeff.setpoint <= tweezer_pkg::SETPOINT_RESET;
            coeff.limit_hi <= tweezer_pkg::LIMIT_HI_RESET;
            coeff.limit_lo <= tweezer_pkg::LIMIT_LO_RESET;
        end else if (cfg_valid) begin
            case (cfg_addr)
                tweezer_pkg::CFG_KP: begin
                    coeff.kp <= cfg_payload.coeff_view.coeff;
                end
                tweezer_pkg::CFG_KI: begin
                    coeff.ki <= cfg_payload.coeff_view.coeff;
                end
                tweezer_pkg::CFG_SETPOINT: begin
                    // Q1.15 setpoint sits in the low half of the coefficient field
                    coeff.setpoint <= cfg_payload.coeff_view.coeff[15:0];
                end
                tweezer_pkg::CFG_LIMITS: begin
                    coeff.limit_hi <= cfg_payload.limits_view.limit_hi;
                    coeff.limit_lo <= cfg_payload.limits_view.limit_lo;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pi_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module pi_controller (
    input  wire                        clk_adc,
    input  wire                        rst,
    input  wire                        pi_enable,
    input  wire                        pi_freeze,
    input  wire                        pi_reset,
    pi_coeff_if.ctrl                   coeff,
    sample_if.dst                      smp,
    output logic                       out_valid,
    input  wire                        out_ready,
    output tweezer_pkg::sample_t       out_data
);

    function automatic tweezer_pkg::sample_t clamp_to_limits(
        input logic signed [18:0]    value,
        input tweezer_pkg::sample_t  lo,
        input tweezer_pkg::sample_t  hi
    );
        if (value > 19'(hi))
            return hi;
        else if (value < 19'(lo))
            return lo;
        else
            return tweezer_pkg::sample_t'(value[15:0]);
    endfunction

    logic signed [16:0]   err;
    logic signed [42:0]   p_prod;
    logic signed [42:0]   i_prod;
    logic                 s1_valid;
    logic                 s1_sat;
    logic signed [17:0]   s1_p;
    logic signed [17:0]   s1_i;
    logic                 s1_free;
    logic                 s2_free;
    logic                 s2_load;
    logic                 hold_off;
    tweezer_pkg::sample_t hi_bound;
    tweezer_pkg::sample_t lo_bound;
    tweezer_pkg::sample_t integ;
    tweezer_pkg::sample_t integ_upd;
    tweezer_pkg::sample_t out_next;

    // Stage 1: error and both products, floored back to sample scale
    assign err    = 17'(coeff.setpoint) - 17'(smp.data);
    assign p_prod = err * coeff.kp;
    assign i_prod = err * coeff.ki;

    // Handshake, whole pipeline stalls behind out_ready
    assign s2_free   = !out_valid || out_ready;
    assign s1_free   = !s1_valid || s2_free;
    assign s2_load   = s1_valid && s2_free;
    assign smp.ready = s1_free;

    always_ff @(posedge clk_adc) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (s1_free) begin
            s1_valid <= smp.valid;
        end
    end

    always_ff @(posedge clk_adc) begin
        if (smp.valid && s1_free) begin
            s1_p   <= 18'(p_prod >>> tweezer_pkg::COEFF_FRAC);
            s1_i   <= 18'(i_prod >>> tweezer_pkg::COEFF_FRAC);
            s1_sat <= smp.saturated;
        end
    end

    // Stage 2: integrator and output, both held inside the limits
    assign hi_bound = {coeff.limit_hi, 2'b00};
    assign lo_bound = {coeff.limit_lo, 2'b00};
    assign hold_off = !pi_enable || pi_reset;

    always_comb begin
        if (pi_freeze)
            integ_upd = integ;
        else
            integ_upd = clamp_to_limits(19'(integ) + 19'(s1_i), lo_bound, hi_bound);

        if (hold_off)
            out_next = '0;
        else if (s1_sat)
            out_next = out_data;
        else
            out_next = clamp_to_limits(19'(s1_p) + 19'(integ_upd), lo_bound, hi_bound);
    end

    always_ff @(posedge clk_adc) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            integ     <= '0;
        end else begin
            if (s2_free) begin
                out_valid <= s1_valid;
            end
            if (s2_load) begin
                out_data <= out_next;
            end
            // Cleared while held off, even with nothing in flight
            if (hold_off) begin
                integ <= '0;
            end else if (s2_load && !s1_sat) begin
                integ <= integ_upd;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sample_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Selected ADC sample on its way into the controller
interface sample_if;
    logic                 valid;
    logic                 ready;
    tweezer_pkg::sample_t data;
    logic                 saturated;

    modport src (
        output valid, data, saturated,
        input  ready
    );

    modport dst (
        input  valid, data, saturated,
        output ready
    );
endinterface

`default_nettype wire

// ==== hdl/tweezer_pi_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tweezer_pi_top (
    input  wire                                  clk_adc,
    input  wire                                  rst,
    input  wire tweezer_pkg::sample_t            adc_a,
    input  wire tweezer_pkg::sample_t            adc_b,
    input  wire tweezer_pkg::sample_t            adc_c,
    input  wire tweezer_pkg::sample_t            adc_d,
    input  wire                                  adc_valid,
    input  wire [1:0]                            ch_sel,
    input  wire                                  cfg_valid,
    input  wire tweezer_pkg::cfg_addr_t          cfg_addr,
    input  wire tweezer_pkg::cfg_payload_u       cfg_payload,
    input  wire                                  pi_enable,
    input  wire                                  pi_freeze,
    input  wire                                  pi_reset,
    output wire                                  dac_sclk,
    output wire                                  dac_cs_n,
    output wire                                  dac_sdo,
    output wire [tweezer_pkg::NUM_CHANNELS-1:0]  sat_flags,
    output wire                                  overrun
);

    sample_if   i_sample_if ();
    pi_coeff_if i_pi_coeff_if ();

    wire                  out_valid;
    wire                  out_ready;
    tweezer_pkg::sample_t out_data;

    adc_input_stage i_adc_input_stage (
        .clk_adc   (clk_adc),
        .rst       (rst),
        .adc_a     (adc_a),
        .adc_b     (adc_b),
        .adc_c     (adc_c),
        .adc_d     (adc_d),
        .adc_valid (adc_valid),
        .ch_sel    (ch_sel),
        .sat_flags (sat_flags),
        .overrun   (overrun),
        .smp       (i_sample_if.src)
    );

    pi_config_regs i_pi_config_regs (
        .clk_adc     (clk_adc),
        .rst         (rst),
        .cfg_valid   (cfg_valid),
        .cfg_addr    (cfg_addr),
        .cfg_payload (cfg_payload),
        .coeff       (i_pi_coeff_if.regs)
    );

    pi_controller i_pi_controller (
        .clk_adc   (clk_adc),
        .rst       (rst),
        .pi_enable (pi_enable),
        .pi_freeze (pi_freeze),
        .pi_reset  (pi_reset),
        .coeff     (i_pi_coeff_if.ctrl),
        .smp       (i_sample_if.dst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    dac_serializer i_dac_serializer (
        .clk_adc   (clk_adc),
        .rst       (rst),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .dac_sclk  (dac_sclk),
        .dac_cs_n  (dac_cs_n),
        .dac_sdo   (dac_sdo)
    );

endmodule

`default_nettype wire

// ==== hdl/tweezer_pkg.sv ====
`default_nettype none

package tweezer_pkg;

    // Q1.15 ADC sample and DAC word
    typedef logic signed [15:0] sample_t;

    // Q1.25 PI coefficient
    typedef logic signed [25:0] coeff_t;

    // Upper 14 bits of a 16-bit output bound
    typedef logic signed [13:0] limit_t;

    typedef logic [1:0] cfg_addr_t;

    localparam cfg_addr_t CFG_KP       = 2'd0;
    localparam cfg_addr_t CFG_KI       = 2'd1;
    localparam cfg_addr_t CFG_SETPOINT = 2'd2;
    localparam cfg_addr_t CFG_LIMITS   = 2'd3;

    // One 28-bit write word, seen as a coefficient or as a limits pair
    typedef union packed {
        struct packed {
            logic [1:0] pad;
            coeff_t     coeff;
        } coeff_view;
        struct packed {
            limit_t limit_hi;
            limit_t limit_lo;
        } limits_view;
    } cfg_payload_u;

    localparam int COEFF_FRAC   = 25;
    localparam int NUM_CHANNELS = 4;

    localparam sample_t SAT_POS = 16'sh7FFF;
    localparam sample_t SAT_NEG = 16'sh8000;

    // Offset binary for the AD5541A
    localparam logic [15:0] DAC_OFFSET = 16'h8000;
    localparam int DAC_BITS       = 16;
    localparam int CS_IDLE_CYCLES = 2;

    localparam coeff_t  KP_RESET       = '0;
    localparam coeff_t  KI_RESET       = '0;
    localparam sample_t SETPOINT_RESET = '0;
    localparam limit_t  LIMIT_HI_RESET = 14'h1FFF;
    localparam limit_t  LIMIT_LO_RESET = 14'h2000;

endpackage

`default_nettype wire

// ==== sources.f ====
hdl/tweezer_pkg.sv
hdl/sample_if.sv
hdl/pi_coeff_if.sv
hdl/adc_input_stage.sv
hdl/pi_config_regs.sv
hdl/pi_controller.sv
hdl/dac_serializer.sv
hdl/tweezer_pi_top.sv
tests/tb_tweezer_pi.sv

// ==== tests/tb_tweezer_pi.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_tweezer_pi;

    localparam int FRAME_TIMEOUT = 200;
    localparam int SCLK_TIMEOUT  = 8;
    localparam int IDLE_TIMEOUT  = 500;

    logic                       clk_adc;
    logic                       rst;
    tweezer_pkg::sample_t       adc_a;
    tweezer_pkg::sample_t       adc_b;
    tweezer_pkg::sample_t       adc_c;
    tweezer_pkg::sample_t       adc_d;
    logic                       adc_valid;
    logic [1:0]                 ch_sel;
    logic                       cfg_valid;
    tweezer_pkg::cfg_addr_t     cfg_addr;
    tweezer_pkg::cfg_payload_u  cfg_payload;
    logic                       pi_enable;
    logic                       pi_freeze;
    logic                       pi_reset;
    wire                        dac_sclk;
    wire                        dac_cs_n;
    wire                        dac_sdo;
    wire [tweezer_pkg::NUM_CHANNELS-1:0] sat_flags;
    wire                        overrun;

    // Reference state mirrored from the configuration writes
    tweezer_pkg::coeff_t  kp_m;
    tweezer_pkg::coeff_t  ki_m;
    tweezer_pkg::sample_t sp_m;
    tweezer_pkg::limit_t  lim_hi_m;
    tweezer_pkg::limit_t  lim_lo_m;
    longint               integ_m;
    longint               out_m;

    integer seed;
    int     checks;
    int     errors;

    tweezer_pi_top i_tweezer_pi_top (
        .clk_adc     (clk_adc),
        .rst         (rst),
        .adc_a       (adc_a),
        .adc_b       (adc_b),
        .adc_c       (adc_c),
        .adc_d       (adc_d),
        .adc_valid   (adc_valid),
        .ch_sel      (ch_sel),
        .cfg_valid   (cfg_valid),
        .cfg_addr    (cfg_addr),
        .cfg_payload (cfg_payload),
        .pi_enable   (pi_enable),
        .pi_freeze   (pi_freeze),
        .pi_reset    (pi_reset),
        .dac_sclk    (dac_sclk),
        .dac_cs_n    (dac_cs_n),
        .dac_sdo     (dac_sdo),
        .sat_flags   (sat_flags),
        .overrun     (overrun)
    );

    initial begin
        clk_adc = 1'b0;
        forever #5 clk_adc = ~clk_adc;
    end

    task automatic check_word(input string name, input tweezer_pkg::sample_t got,
                              input tweezer_pkg::sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flags(input logic [tweezer_pkg::NUM_CHANNELS-1:0] got,
                               input logic [tweezer_pkg::NUM_CHANNELS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL sat_flags: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [3:0] expected_sat_flags(input tweezer_pkg::sample_t a,
        input tweezer_pkg::sample_t b, input tweezer_pkg::sample_t c,
        input tweezer_pkg::sample_t d);
        logic [3:0] f;
        f[0] = (a == 16'sh7FFF) || (a == 16'sh8000);
        f[1] = (b == 16'sh7FFF) || (b == 16'sh8000);
        f[2] = (c == 16'sh7FFF) || (c == 16'sh8000);
        f[3] = (d == 16'sh7FFF) || (d == 16'sh8000);
        return f;
    endfunction

    // Output bound is the 14-bit limit times 4
    function automatic longint limit_to_range(input longint value);
        longint hi;
        longint lo;
        hi = longint'(lim_hi_m) * 4;
        lo = longint'(lim_lo_m) * 4;
        if (value > hi)
            return hi;
        if (value < lo)
            return lo;
        return value;
    endfunction

    // PI reference giving the offset-binary DAC word for one sample
    task automatic predict_word(input tweezer_pkg::sample_t smp_val,
                                output tweezer_pkg::sample_t word);
        longint err;
        longint p;
        longint inc;
        longint integ_next;
        err = longint'(sp_m) - longint'(smp_val);
        p   = (err * longint'(kp_m)) >>> 25;
        inc = (err * longint'(ki_m)) >>> 25;
        if (pi_freeze)
            integ_next = integ_m;
        else
            integ_next = limit_to_range(integ_m + inc);
        if (!pi_enable || pi_reset) begin
            integ_m = 0;
            out_m   = 0;
        end else if (smp_val != 16'sh7FFF && smp_val != 16'sh8000) begin
            integ_m = integ_next;
            out_m   = limit_to_range(p + integ_next);
        end
        word = tweezer_pkg::sample_t'(out_m + 32'h8000);
    endtask

    task automatic write_cfg(input tweezer_pkg::cfg_addr_t addr,
                             input tweezer_pkg::cfg_payload_u payload);
        @(negedge clk_adc);
        cfg_valid   = 1'b1;
        cfg_addr    = addr;
        cfg_payload = payload;
        @(negedge clk_adc);
        cfg_valid   = 1'b0;
    endtask

    task automatic set_coeff(input tweezer_pkg::cfg_addr_t addr,
                             input tweezer_pkg::coeff_t value);
        tweezer_pkg::cfg_payload_u payload;
        payload = '0;
        payload.coeff_view.coeff = value;
        write_cfg(addr, payload);
        if (addr == 2'd0)
            kp_m = value;
        else
            ki_m = value;
    endtask

    task automatic set_setpoint(input tweezer_pkg::sample_t value);
        tweezer_pkg::cfg_payload_u payload;
        payload = '0;
        payload.coeff_view.coeff[15:0] = value;
        write_cfg(2'd2, payload);
        sp_m = value;
    endtask

    task automatic set_limits(input tweezer_pkg::limit_t hi, input tweezer_pkg::limit_t lo);
        tweezer_pkg::cfg_payload_u payload;
        payload.limits_view.limit_hi = hi;
        payload.limits_view.limit_lo = lo;
        write_cfg(2'd3, payload);
        lim_hi_m = hi;
        lim_lo_m = lo;
    endtask

    task automatic drive_sample(input tweezer_pkg::sample_t a, input tweezer_pkg::sample_t b,
        input tweezer_pkg::sample_t c, input tweezer_pkg::sample_t d, input logic [1:0] sel);
        @(negedge clk_adc);
        adc_a     = a;
        adc_b     = b;
        adc_c     = c;
        adc_d     = d;
        ch_sel    = sel;
        adc_valid = 1'b1;
        @(negedge clk_adc);
        adc_valid = 1'b0;
    endtask

    // Frame starts at the falling cs_n and bits are read while sclk is high
    task automatic capture_frame(output tweezer_pkg::sample_t word, output bit ok);
        int   n;
        int   b;
        logic prev_cs;
        bit   found;
        ok    = 1'b1;
        word  = '0;
        found = 1'b0;
        n     = 0;
        while (!found && n < FRAME_TIMEOUT) begin
            prev_cs = dac_cs_n;
            @(negedge clk_adc);
            found = prev_cs && !dac_cs_n;
            n++;
        end
        if (!found) begin
            errors++;
            ok = 1'b0;
            $display("ERROR: timed out waiting for dac_cs_n to fall");
            return;
        end
        for (b = 15; b >= 0; b--) begin
            n = 0;
            while (dac_sclk !== 1'b1 && n < SCLK_TIMEOUT) begin
                @(negedge clk_adc);
                n++;
            end
            if (dac_sclk !== 1'b1) begin
                errors++;
                ok = 1'b0;
                $display("ERROR: dac_sclk stopped toggling in the middle of a frame");
                return;
            end
            word[b] = dac_sdo;
            n = 0;
            while (dac_sclk !== 1'b0 && n < SCLK_TIMEOUT) begin
                @(negedge clk_adc);
                n++;
            end
            if (dac_sclk !== 1'b0) begin
                errors++;
                ok = 1'b0;
                $display("ERROR: dac_sclk stuck high in the middle of a frame");
                return;
            end
        end
    endtask

    task automatic run_sample(input tweezer_pkg::sample_t a, input tweezer_pkg::sample_t b,
        input tweezer_pkg::sample_t c, input tweezer_pkg::sample_t d, input logic [1:0] sel);
        tweezer_pkg::sample_t chans [4];
        tweezer_pkg::sample_t expected;
        tweezer_pkg::sample_t got;
        bit                   ok;
        chans = '{a, b, c, d};
        drive_sample(a, b, c, d, sel);
        predict_word(chans[sel], expected);
        capture_frame(got, ok);
        if (ok)
            check_word("dac_sdo", got, expected);
        check_flags(sat_flags, expected_sat_flags(a, b, c, d));
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("test %s done, %0d errors", name, errors - start_errors);
    endtask

    task automatic test_proportional();
        int start_errors;
        int i;
        start_errors = errors;
        set_coeff(2'd0, 26'sd1 <<< 24);
        set_coeff(2'd1, '0);
        pi_enable = 1'b1;
        for (i = 0; i < 8; i++)
            run_sample(tweezer_pkg::sample_t'($random(seed)), '0, '0, '0, 2'd0);
        report_test("proportional", start_errors);
    endtask

    task automatic test_integral();
        int start_errors;
        int i;
        start_errors = errors;
        set_coeff(2'd0, '0);
        set_coeff(2'd1, 26'sd1 <<< 22);
        set_setpoint(16'sh1000);
        for (i = 0; i < 4; i++)
            run_sample('0, '0, '0, '0, 2'd0);
        // Words hold while the integrator is frozen
        pi_freeze = 1'b1;
        for (i = 0; i < 2; i++)
            run_sample('0, '0, '0, '0, 2'd0);
        pi_reset = 1'b1;
        run_sample('0, '0, '0, '0, 2'd0);
        pi_reset  = 1'b0;
        pi_freeze = 1'b0;
        report_test("integral", start_errors);
    endtask

    task automatic test_limits();
        int start_errors;
        start_errors = errors;
        set_coeff(2'd0, 26'sd1 <<< 24);
        set_coeff(2'd1, '0);
        set_setpoint('0);
        set_limits(14'sh0100, -14'sh0100);
        run_sample(16'sh4000, '0, '0, '0, 2'd0);
        run_sample(-16'sh4000, '0, '0, '0, 2'd0);
        run_sample(16'sh0200, '0, '0, '0, 2'd0);
        run_sample(16'sh7000, '0, '0, '0, 2'd0);
        run_sample(-16'sh7000, '0, '0, '0, 2'd0);
        set_limits(14'sh1FFF, 14'sh2000);
        report_test("limits", start_errors);
    endtask

    task automatic test_channels();
        int start_errors;
        int i;
        start_errors = errors;
        for (i = 0; i < 4; i++)
            run_sample(16'sh0400, -16'sh0800, 16'sh1200, -16'sh2200, 2'(i));
        // Saturated channel C repeats the last word
        run_sample(16'sh0400, -16'sh0800, 16'sh7FFF, -16'sh2200, 2'd2);
        report_test("channel select", start_errors);
    endtask

    task automatic test_disable();
        int start_errors;
        int i;
        start_errors = errors;
        set_coeff(2'd1, 26'sd1 <<< 22);
        set_setpoint(16'sh1000);
        pi_enable = 1'b0;
        for (i = 0; i < 4; i++)
            run_sample(tweezer_pkg::sample_t'($random(seed)), '0, '0, '0, 2'd0);
        pi_enable = 1'b1;
        report_test("disable", start_errors);
    endtask

    task automatic test_overrun();
        int start_errors;
        int i;
        int quiet;
        start_errors = errors;
        check_bit("overrun", overrun, 1'b0);
        for (i = 0; i < 40; i++) begin
            @(negedge clk_adc);
            adc_a     = tweezer_pkg::sample_t'($random(seed));
            ch_sel    = 2'd0;
            adc_valid = 1'b1;
        end
        @(negedge clk_adc);
        adc_valid = 1'b0;
        check_bit("overrun", overrun, 1'b1);
        // Let the queued frames drain
        quiet = 0;
        i     = 0;
        while (quiet < 8 && i < IDLE_TIMEOUT) begin
            @(negedge clk_adc);
            quiet = dac_cs_n ? quiet + 1 : 0;
            i++;
        end
        if (quiet < 8) begin
            errors++;
            $display("ERROR: DAC output never went idle after the burst");
        end
        check_bit("overrun", overrun, 1'b1);
        rst = 1'b1;
        repeat (2) @(negedge clk_adc);
        rst = 1'b0;
        check_bit("overrun", overrun, 1'b0);
        report_test("overrun", start_errors);
    endtask

    initial begin
        rst         = 1'b1;
        adc_a       = '0;
        adc_b       = '0;
        adc_c       = '0;
        adc_d       = '0;
        adc_valid   = 1'b0;
        ch_sel      = 2'd0;
        cfg_valid   = 1'b0;
        cfg_addr    = '0;
        cfg_payload = '0;
        pi_enable   = 1'b0;
        pi_freeze   = 1'b0;
        pi_reset    = 1'b0;
        seed        = 28;
        checks      = 0;
        errors      = 0;
        kp_m        = '0;
        ki_m        = '0;
        sp_m        = '0;
        lim_hi_m    = 14'h1FFF;
        lim_lo_m    = 14'h2000;
        integ_m     = 0;
        out_m       = 0;
        repeat (2) @(negedge clk_adc);
        rst = 1'b0;
        check_bit("dac_cs_n", dac_cs_n, 1'b1);
        check_bit("dac_sclk", dac_sclk, 1'b0);
        test_proportional();
        test_integral();
        test_limits();
        test_channels();
        test_disable();
        test_overrun();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
